// File: src/ifetch_pkg.sv
package ifetch_pkg;

    // address and instruction word width.
    localparam int XLEN = 32;

    // byte offset bits inside one instruction word.
    localparam int WORD_OFFSET_W = 2;

    typedef struct packed {
        logic [XLEN-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
    } fetch_rsp_t;

    // word address, not byte address.
    typedef struct packed {
        logic [XLEN-1:0] word_addr;
    } mem_req_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetch_out_t;

    typedef struct packed {
        logic [XLEN-1:0] index;
        logic [XLEN-1:0] data;
    } prog_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE_TAG,
        ALLOCATE
    } cache_state_e;

    typedef enum logic [1:0] {
        REQUEST,
        WAIT,
        HOLD
    } fetch_state_e;

endpackage

// File: src/fetch_unit.sv
`timescale 1ns/100ps

module fetch_unit #(
    parameter logic [ifetch_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redirect_valid,
    input  logic [ifetch_pkg::XLEN-1:0] redirect_pc,
    output logic                        req_valid,
    output ifetch_pkg::fetch_req_t      req,
    input  logic                        req_ready,
    input  logic                        rsp_valid,
    input  ifetch_pkg::fetch_rsp_t      rsp,
    output logic                        out_valid,
    output ifetch_pkg::fetch_out_t      out,
    input  logic                        out_ready
);

    ifetch_pkg::fetch_state_e    state;
    logic [ifetch_pkg::XLEN-1:0] pc;
    logic                        drop;
    logic                        req_fire;
    logic                        in_flight;

    // no new request until the stale response has gone by.
    assign req_valid = (state == ifetch_pkg::REQUEST) && !drop;
    assign req.addr  = pc;
    assign req_fire  = req_valid && req_ready;

    // a response is still owed to us after this edge.
    assign in_flight = req_fire
                       || ((state == ifetch_pkg::WAIT) && !rsp_valid)
                       || (drop && !rsp_valid);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ifetch_pkg::REQUEST;
            pc        <= RESET_PC;
            drop      <= 1'b0;
            out_valid <= 1'b0;
        end
        else if (redirect_valid)
        begin
            state     <= ifetch_pkg::REQUEST;
            pc        <= redirect_pc;
            drop      <= in_flight;
            out_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ifetch_pkg::REQUEST:
                begin
                    // stale response from before a redirect.
                    if (rsp_valid)
                        drop <= 1'b0;
                    if (req_fire)
                        state <= ifetch_pkg::WAIT;
                end
                ifetch_pkg::WAIT:
                begin
                    if (rsp_valid)
                    begin
                        state     <= ifetch_pkg::HOLD;
                        out_valid <= 1'b1;
                    end
                end
                ifetch_pkg::HOLD:
                begin
                    if (out_ready)
                    begin
                        state     <= ifetch_pkg::REQUEST;
                        out_valid <= 1'b0;
                        pc        <= pc + 4;
                    end
                end
                default:
                    state <= ifetch_pkg::REQUEST;
            endcase
        end
    end

    // instruction register, loaded from the cache response.
    always_ff @(posedge clk)
    begin
        if ((state == ifetch_pkg::WAIT) && rsp_valid)
        begin
            out.pc    <= pc;
            out.instr <= rsp.instr;
        end
    end

endmodule

// File: src/icache.sv
`timescale 1ns/100ps

module icache #(
    parameter int LINES = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        req_valid,
    input  ifetch_pkg::fetch_req_t      req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output ifetch_pkg::fetch_rsp_t      rsp,
    output logic                        mem_req_valid,
    output ifetch_pkg::mem_req_t        mem_req,
    input  logic                        mem_req_ready,
    input  logic                        mem_rsp_valid,
    input  logic [ifetch_pkg::XLEN-1:0] mem_rsp_data
);

    localparam int OFFSET_W = ifetch_pkg::WORD_OFFSET_W;
    localparam int INDEX_W  = $clog2(LINES);
    localparam int TAG_W    = ifetch_pkg::XLEN - INDEX_W - OFFSET_W;

    ifetch_pkg::cache_state_e    state;
    ifetch_pkg::fetch_req_t      req_q;
    logic [LINES-1:0]            line_valid;
    logic [TAG_W-1:0]            tag_mem [LINES];
    logic [ifetch_pkg::XLEN-1:0] data_mem [LINES];
    logic [INDEX_W-1:0]          index;
    logic [TAG_W-1:0]            tag;
    logic                        hit;
    logic                        mem_issued;
    logic                        fill_done;
    logic                        fill_write;
    logic                        flushed;

    // word offset, then index, then tag.
    assign index = req_q.addr[OFFSET_W +: INDEX_W];
    assign tag   = req_q.addr[ifetch_pkg::XLEN-1 -: TAG_W];
    assign hit   = line_valid[index] && (tag_mem[index] == tag);

    assign req_ready = (state == ifetch_pkg::IDLE);

    // a fill lands in the array first, so both cases read the same line.
    assign rsp_valid = ((state == ifetch_pkg::COMPARE_TAG) && hit)
                       || ((state == ifetch_pkg::ALLOCATE) && fill_done);
    assign rsp.instr = data_mem[index];

    assign mem_req_valid = ((state == ifetch_pkg::COMPARE_TAG) && !hit)
                           || ((state == ifetch_pkg::ALLOCATE) && !mem_issued);
    assign mem_req.word_addr = req_q.addr >> OFFSET_W;

    assign fill_write = (state == ifetch_pkg::ALLOCATE) && !fill_done && mem_rsp_valid;

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            req_q <= req;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= ifetch_pkg::IDLE;
            mem_issued <= 1'b0;
            fill_done  <= 1'b0;
            flushed    <= 1'b0;
        end
        else
        begin
            case (state)
                ifetch_pkg::IDLE:
                begin
                    if (req_valid)
                        state <= ifetch_pkg::COMPARE_TAG;
                end
                ifetch_pkg::COMPARE_TAG:
                begin
                    if (!hit)
                    begin
                        state      <= ifetch_pkg::ALLOCATE;
                        mem_issued <= mem_req_ready;
                        flushed    <= 1'b0;
                    end
                    else
                        state <= ifetch_pkg::IDLE;
                end
                ifetch_pkg::ALLOCATE:
                begin
                    if (mem_req_valid && mem_req_ready)
                        mem_issued <= 1'b1;
                    if (flush)
                        flushed <= 1'b1;
                    if (fill_done)
                    begin
                        state      <= ifetch_pkg::IDLE;
                        fill_done  <= 1'b0;
                        mem_issued <= 1'b0;
                        flushed    <= 1'b0;
                    end
                    else if (mem_rsp_valid)
                        fill_done <= 1'b1;
                end
                default:
                    state <= ifetch_pkg::IDLE;
            endcase
        end
    end

    // refill still completes after a flush, but the line stays invalid.
    always_ff @(posedge clk)
    begin
        if (rst || flush)
            line_valid <= '0;
        else if (fill_write)
            line_valid[index] <= !flushed;
    end

    always_ff @(posedge clk)
    begin
        if (fill_write)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= mem_rsp_data;
        end
    end

endmodule

// File: src/imem.sv
`timescale 1ns/100ps

module imem #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        prog_valid,
    input  ifetch_pkg::prog_wr_t        prog,
    input  logic                        req_valid,
    input  ifetch_pkg::mem_req_t        req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output logic [ifetch_pkg::XLEN-1:0] rsp_data
);

    localparam int ADDR_W = $clog2(MEM_WORDS);
    localparam int CNT_W  = $clog2(MEM_LATENCY + 1);

    logic [ifetch_pkg::XLEN-1:0] mem_q [MEM_WORDS];
    logic [ADDR_W-1:0]           addr_q;
    logic [CNT_W-1:0]            count;
    logic                        busy;

    assign req_ready = !busy;
    assign rsp_valid = busy && (count == '0);

    // read at response time, so late program writes are visible.
    assign rsp_data = mem_q[addr_q];

    always_ff @(posedge clk)
    begin
        if (prog_valid)
            mem_q[ADDR_W'(prog.index % MEM_WORDS)] <= prog.data;
    end

    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
            addr_q <= ADDR_W'(req.word_addr % MEM_WORDS);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy  <= 1'b0;
            count <= '0;
        end
        else if (req_valid && req_ready)
        begin
            busy  <= 1'b1;
            count <= CNT_W'(MEM_LATENCY - 1);
        end
        else if (busy)
        begin
            if (count == '0)
                busy <= 1'b0;
            else
                count <= count - 1'b1;
        end
    end

endmodule

// File: src/ifetch_top.sv
`timescale 1ns/100ps

module ifetch_top #(
    parameter int                          LINES       = 16,
    parameter int                          MEM_WORDS   = 256,
    parameter int                          MEM_LATENCY = 3,
    parameter logic [ifetch_pkg::XLEN-1:0] RESET_PC    = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        redirect_valid,
    input  logic [ifetch_pkg::XLEN-1:0] redirect_pc,
    input  logic                        flush,
    input  logic                        prog_valid,
    input  ifetch_pkg::prog_wr_t        prog,
    output logic                        out_valid,
    output ifetch_pkg::fetch_out_t      out,
    input  logic                        out_ready
);

    // fetch unit to cache.
    logic                        fetch_req_valid;
    ifetch_pkg::fetch_req_t      fetch_req;
    logic                        fetch_req_ready;
    logic                        fetch_rsp_valid;
    ifetch_pkg::fetch_rsp_t      fetch_rsp;

    // cache to instruction memory.
    logic                        mem_req_valid;
    ifetch_pkg::mem_req_t        mem_req;
    logic                        mem_req_ready;
    logic                        mem_rsp_valid;
    logic [ifetch_pkg::XLEN-1:0] mem_rsp_data;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch_unit (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .req_valid      (fetch_req_valid),
        .req            (fetch_req),
        .req_ready      (fetch_req_ready),
        .rsp_valid      (fetch_rsp_valid),
        .rsp            (fetch_rsp),
        .out_valid      (out_valid),
        .out            (out),
        .out_ready      (out_ready)
    );

    icache #(
        .LINES (LINES)
    ) u_icache (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .req_valid     (fetch_req_valid),
        .req           (fetch_req),
        .req_ready     (fetch_req_ready),
        .rsp_valid     (fetch_rsp_valid),
        .rsp           (fetch_rsp),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    imem #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_imem (
        .clk        (clk),
        .rst        (rst),
        .prog_valid (prog_valid),
        .prog       (prog),
        .req_valid  (mem_req_valid),
        .req        (mem_req),
        .req_ready  (mem_req_ready),
        .rsp_valid  (mem_rsp_valid),
        .rsp_data   (mem_rsp_data)
    );

endmodule

// File: tb/ifetch_asserts.sv
`timescale 1ns/100ps

module ifetch_asserts (
    input logic                     clk,
    input logic                     rst,
    input logic                     req_valid,
    input ifetch_pkg::fetch_req_t   req,
    input logic                     req_ready,
    input logic                     rsp_valid,
    input logic                     mem_req_valid,
    input ifetch_pkg::mem_req_t     mem_req,
    input logic                     mem_req_ready,
    input logic                     mem_rsp_valid,
    input ifetch_pkg::cache_state_e state,
    input logic                     hit
);

    // an accepted request still waiting for its response.
    logic pending;

    // number of failed assertions so far.
    int   fail_count = 0;

    always_ff @(posedge clk)
    begin
        if (rst)
            pending <= 1'b0;
        else if (req_valid && req_ready)
            pending <= 1'b1;
        else if (rsp_valid)
            pending <= 1'b0;
    end

    req_stable: assert property (@(posedge clk) disable iff (rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req)))
        else
        begin
            $error("fetch request changed before it was accepted.");
            fail_count++;
        end

    mem_req_stable: assert property (@(posedge clk) disable iff (rst)
        (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_req)))
        else
        begin
            $error("memory request changed before it was accepted.");
            fail_count++;
        end

    // a refill answers only in the cycle after the memory data.
    rsp_legal: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> (((state == ifetch_pkg::COMPARE_TAG) && hit)
                       || ((state == ifetch_pkg::ALLOCATE) && $past(mem_rsp_valid))))
        else
        begin
            $error("response outside a hit or a refill.");
            fail_count++;
        end

    rsp_owed: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> pending)
        else
        begin
            $error("response without an accepted request.");
            fail_count++;
        end

    one_outstanding: assert property (@(posedge clk) disable iff (rst)
        (req_valid && req_ready) |-> !pending)
        else
        begin
            $error("new request accepted before the previous response.");
            fail_count++;
        end

endmodule

bind icache ifetch_asserts u_ifetch_asserts (
    .clk           (clk),
    .rst           (rst),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .rsp_valid     (rsp_valid),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .state         (state),
    .hit           (hit)
);

// File: tb/ifetch_tb.sv
`timescale 1ns/100ps

module ifetch_tb;

    localparam int LINES       = 16;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_LATENCY = 3;
    localparam int INDEX_W     = $clog2(LINES);
    localparam int MAX_CMDS    = 64;

    logic                        clk;
    logic                        rst;
    logic                        redirect_valid;
    logic [ifetch_pkg::XLEN-1:0] redirect_pc;
    logic                        flush;
    logic                        prog_valid;
    ifetch_pkg::prog_wr_t        prog;
    logic                        out_valid;
    ifetch_pkg::fetch_out_t      out;
    logic                        out_ready;

    // commands from the cases file.
    byte             cmd_op   [MAX_CMDS];
    logic [31:0]     cmd_a    [MAX_CMDS];
    logic [31:0]     cmd_b    [MAX_CMDS];
    logic [8*24-1:0] cmd_name [MAX_CMDS];
    int              n_cmds;

    // reference memory and the lines the cache should hold.
    logic [31:0]     model_mem  [MEM_WORDS];
    logic            model_vld  [LINES];
    logic [31:0]     model_tag  [LINES];
    logic [31:0]     model_data [LINES];

    logic [15:0]     lfsr;
    logic [31:0]     exp_pc;
    logic [8*24-1:0] test_name;
    logic            test_open;
    int              test_checks;
    int              test_errors;
    int              tests_passed;
    int              tests_failed;
    int              total_errors;
    int              total_consumed;
    int              cycle_limit;
    int              cycles;
    logic            running;

    ifetch_top DUT (
        .clk            (clk),
        .rst            (rst),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush),
        .prog_valid     (prog_valid),
        .prog           (prog),
        .out_valid      (out_valid),
        .out            (out),
        .out_ready      (out_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        if (running)
        begin
            cycles = cycles + 1;
            if (cycles > cycle_limit)
            begin
                $display("timeout: cases did not finish within %0d cycles", cycle_limit);
                $display("TEST RESULT: FAIL");
                $finish;
            end
        end
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0])
            return (s >> 1) ^ 16'hB400;
        return s >> 1;
    endfunction

    // every word gets a value built from its whole index.
    function automatic logic [31:0] fill_word(input int i);
        logic [7:0] a;
        a = i[7:0];
        return {a, ~a, 8'h13, a ^ 8'h5A};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_word(input logic [31:0] index, input logic [31:0] data);
        prog_valid = 1'b1;
        prog.index = index;
        prog.data  = data;
        model_mem[index % MEM_WORDS] = data;
        next_cycle();
        prog_valid = 1'b0;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        for (int i = 0; i < LINES; i++)
            model_vld[i] = 1'b0;
        next_cycle();
        flush = 1'b0;
    endtask

    task automatic close_test();
        if (test_open)
        begin
            $display("test %0s: %0d instructions checked, %0d errors",
                     test_name, test_checks, test_errors);
            if (test_errors == 0)
                tests_passed++;
            else
                tests_failed++;
        end
        test_open = 1'b0;
    endtask

    task automatic start_test(input logic [8*24-1:0] name, input logic [31:0] pc);
        close_test();
        test_name   = name;
        test_open   = 1'b1;
        test_checks = 0;
        test_errors = 0;
        exp_pc      = pc;
        // lets the next sequential miss get under way first.
        repeat (3)
            next_cycle();
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        next_cycle();
        redirect_valid = 1'b0;
    endtask

    task automatic check_instr();
        logic [INDEX_W-1:0] idx;
        logic [31:0]        tag;
        logic [31:0]        exp_instr;
        idx = exp_pc[2 +: INDEX_W];
        tag = exp_pc >> (2 + INDEX_W);
        if (model_vld[idx] && (model_tag[idx] == tag))
            exp_instr = model_data[idx];
        else
            exp_instr = model_mem[(exp_pc >> 2) % MEM_WORDS];
        model_vld[idx]  = 1'b1;
        model_tag[idx]  = tag;
        model_data[idx] = exp_instr;
        test_checks++;
        if (out.pc !== exp_pc)
        begin
            $display("ERROR test %0s: pc expected %h actual %h", test_name, exp_pc, out.pc);
            test_errors++;
            total_errors++;
        end
        if (out.instr !== exp_instr)
        begin
            $display("ERROR test %0s: instr at pc %h expected %h actual %h",
                     test_name, exp_pc, exp_instr, out.instr);
            test_errors++;
            total_errors++;
        end
        exp_pc = exp_pc + 4;
    endtask

    // random ready each cycle; a transfer is checked while its payload is stable.
    task automatic consume_instrs(input int n);
        int got;
        got = 0;
        while (got < n)
        begin
            next_cycle();
            out_ready = lfsr[0];
            lfsr      = lfsr_step(lfsr);
            if (out_valid && out_ready)
            begin
                check_instr();
                got++;
            end
        end
        next_cycle();
        out_ready = 1'b0;
    endtask

    task automatic read_cases();
        int              fd;
        int              rc;
        byte             op;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [8*24-1:0] name;
        logic [8*80-1:0] rest;
        fd = $fopen("tb/ifetch_cases.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the cases file tb/ifetch_cases.txt");
            total_errors++;
            return;
        end
        while ((n_cmds < MAX_CMDS) && ($fscanf(fd, " %c", op) == 1))
        begin
            a    = '0;
            b    = '0;
            name = '0;
            rc   = 0;
            case (op)
                "#": rc = $fgets(rest, fd);
                "P": rc = $fscanf(fd, " %h %h", a, b);
                "R": rc = $fscanf(fd, " %s %h", name, a);
                "C": rc = $fscanf(fd, " %d", a);
                "F": rc = 0;
                default:
                begin
                    $display("unknown command '%c' in the cases file", op);
                    total_errors++;
                end
            endcase
            if ((((op == "P") || (op == "R")) && (rc != 2)) || ((op == "C") && (rc != 1)))
            begin
                $display("malformed '%c' command in the cases file", op);
                total_errors++;
            end
            if ((op == "P") || (op == "R") || (op == "C") || (op == "F"))
            begin
                cmd_op[n_cmds]   = op;
                cmd_a[n_cmds]    = a;
                cmd_b[n_cmds]    = b;
                cmd_name[n_cmds] = name;
                n_cmds++;
                if (op == "C")
                    total_consumed += a;
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        clk            = 1'b0;
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        flush          = 1'b0;
        prog_valid     = 1'b0;
        prog           = '0;
        out_ready      = 1'b0;
        lfsr           = 16'd68;
        exp_pc         = '0;
        test_name      = '0;
        test_open      = 1'b0;
        test_checks    = 0;
        test_errors    = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        total_errors   = 0;
        total_consumed = 0;
        n_cmds         = 0;
        cycles         = 0;
        cycle_limit    = 0;
        running        = 1'b0;
        for (int i = 0; i < LINES; i++)
            model_vld[i] = 1'b0;
        read_cases();
        cycle_limit = total_consumed * (MEM_LATENCY + 10) + 200;
        repeat (10)
            @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            write_word(i, fill_word(i));
        running = 1'b1;
        for (int k = 0; k < n_cmds; k++)
        begin
            case (cmd_op[k])
                "P": write_word(cmd_a[k], cmd_b[k]);
                "F": flush_cache();
                "R": start_test(cmd_name[k], cmd_a[k]);
                "C": consume_instrs(cmd_a[k]);
                default: ;
            endcase
        end
        close_test();
        running = 1'b0;
        if (DUT.u_icache.u_ifetch_asserts.fail_count != 0)
        begin
            $display("cache assertions failed %0d times",
                     DUT.u_icache.u_ifetch_asserts.fail_count);
            total_errors += DUT.u_icache.u_ifetch_asserts.fail_count;
        end
        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if ((total_errors == 0) && (tests_failed == 0) && (tests_passed > 0))
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb/ifetch_cases.txt
# P index data (hex) | R name pc (hex) | F | C count (decimal)
# R starts a named test at pc, C consumes and checks that many instructions
P 0 00000093
P 1 00100113
P 2 00208193
P 3 00318213
P 4 00420293
P 5 00528313
P 6 00630393
P 7 00738413
F
R cold 0
C 8
R warm 0
C 8
R alias 40
C 4
R miss_run 80
C 2
R redirect 100
C 3
P 5 abcd0005
P 6 abcd0006
P 7 abcd0007
R stale 14
C 3
F
R flushed 14
C 3
R mixed 0
C 12
R far 200
C 10

// File: sim.f
src/ifetch_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/imem.sv
src/ifetch_top.sv
tb/ifetch_asserts.sv
tb/ifetch_tb.sv

// File: Bender.yml
package:
  name: ifetch

sources:
  - src/ifetch_pkg.sv
  - src/fetch_unit.sv
  - src/icache.sv
  - src/imem.sv
  - src/ifetch_top.sv
  - target: test
    files:
      - tb/ifetch_asserts.sv
      - tb/ifetch_tb.sv

# simulation top: ifetch_tb, design top: ifetch_top
